/* src/core_settings.svh */
////////////////////////////////////////////////////////////
// Core settings
// Sizes shared by the package, the RTL and the testbench
////////////////////////////////////////////////////////////
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data path width
`define CORE_XLEN 32

// Architectural registers, 4-bit addresses
`define CORE_NUM_REGS 16

// In-flight instruction IDs, also the ID credit count
`define CORE_NUM_IDS 8

// Input queue entries, also the initial input credits
`define CORE_IN_DEPTH 2

`endif

/* src/core_pkg.sv */
////////////////////////////////////////////////////////////
// Core package
// Opcode, ID, instruction word and inter-stage types
////////////////////////////////////////////////////////////
`default_nettype none

`include "core_settings.svh"

package core_pkg;

    // Opcodes in the top nibble of every word
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_xor  = 4'd2,
        op_addi = 4'd3,
        op_mul  = 4'd4
    } opcode_t;

    typedef logic [$clog2(`CORE_NUM_IDS)-1:0] instr_id_t;
    typedef logic [3:0] reg_addr_t;

    ////////////////////////////////////////////////////////////
    // Instruction word views

    // Register-register view
    typedef struct packed {
        opcode_t     opcode;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [15:0] unused;
    } r_form_t;

    // Register-immediate view, pad sits where rs2 would be
    typedef struct packed {
        opcode_t            opcode;
        reg_addr_t          rd;
        reg_addr_t          rs1;
        logic [3:0]         pad;
        logic signed [15:0] imm;
    } i_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } instr_word_u;

    ////////////////////////////////////////////////////////////
    // Stage to stage packets

    // Issue to unit, b is rs2 or the extended immediate
    typedef struct packed {
        logic                  valid;
        instr_id_t             id;
        opcode_t               opcode;
        logic [`CORE_XLEN-1:0] a;
        logic [`CORE_XLEN-1:0] b;
    } unit_issue_t;

    // Unit to write-back
    typedef struct packed {
        logic                  done;
        instr_id_t             id;
        logic [`CORE_XLEN-1:0] result;
    } unit_wb_t;

    // ID allocation notice
    typedef struct packed {
        logic      valid;
        instr_id_t id;
        reg_addr_t rd;
    } id_alloc_t;

    // One retirement
    typedef struct packed {
        logic                  valid;
        instr_id_t             id;
        reg_addr_t             rd;
        logic [`CORE_XLEN-1:0] data;
    } retire_t;

endpackage

`default_nettype wire

/* src/issue_stage.sv */
////////////////////////////////////////////////////////////
// Issue stage
// Credit-fed input queue, decode, register busy tracking,
// ID credits and in-order dispatch to the ALU or multiplier
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module issue_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    input  core_pkg::instr_word_u   instr,
    output logic                    instr_credit,
    input  logic                    id_credit,
    input  logic                    mul_busy,
    input  core_pkg::retire_t       retire,
    output core_pkg::reg_addr_t     rs1_addr,
    output core_pkg::reg_addr_t     rs2_addr,
    input  logic [`CORE_XLEN-1:0]   rs1_data,
    input  logic [`CORE_XLEN-1:0]   rs2_data,
    output core_pkg::unit_issue_t   alu_issue,
    output core_pkg::unit_issue_t   mul_issue,
    output core_pkg::id_alloc_t     id_alloc
);

    localparam int q_ptr_w = $clog2(`CORE_IN_DEPTH);
    localparam int q_cnt_w = $clog2(`CORE_IN_DEPTH + 1);
    localparam int id_cnt_w = $clog2(`CORE_NUM_IDS + 1);

    core_pkg::instr_word_u q_mem [`CORE_IN_DEPTH];
    logic [q_ptr_w-1:0] wr_ptr, rd_ptr;
    logic [q_cnt_w-1:0] q_cnt;
    logic [id_cnt_w-1:0] id_cnt;
    core_pkg::instr_id_t next_id;
    logic [`CORE_NUM_REGS-1:0] reg_busy;
    core_pkg::instr_id_t last_writer [`CORE_NUM_REGS];

    core_pkg::instr_word_u head;
    core_pkg::opcode_t opcode;
    logic is_imm, is_mul, hold, dispatch;
    logic [`CORE_XLEN-1:0] op_b;

    ////////////////////////////////////////////////////////////
    // Decode of the oldest queued word
    assign head = q_mem[rd_ptr];
    assign opcode = head.r_form.opcode;
    assign is_imm = (opcode == core_pkg::op_addi);
    assign is_mul = (opcode == core_pkg::op_mul);
    assign rs1_addr = head.r_form.rs1;
    assign rs2_addr = head.r_form.rs2;

    // Sign extended immediate replaces rs2
    assign op_b = is_imm ? {{(`CORE_XLEN-16){head.i_form.imm[15]}}, head.i_form.imm} : rs2_data;

    // Any hazard keeps the head in the queue
    assign hold = (id_cnt == '0)
                || reg_busy[head.r_form.rs1]
                || (!is_imm && reg_busy[head.r_form.rs2])
                || (is_mul && mul_busy);
    assign dispatch = (q_cnt != '0) && !hold;

    assign alu_issue = '{valid: dispatch && !is_mul, id: next_id, opcode: opcode,
                         a: rs1_data, b: op_b};
    assign mul_issue = '{valid: dispatch && is_mul, id: next_id, opcode: opcode,
                         a: rs1_data, b: op_b};
    assign id_alloc = '{valid: dispatch, id: next_id, rd: head.r_form.rd};

    ////////////////////////////////////////////////////////////
    // Queue, credits and ID pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_cnt <= '0;
            instr_credit <= 1'b0;
            id_cnt <= id_cnt_w'(`CORE_NUM_IDS);
            next_id <= '0;
        end else begin
            if (instr_valid) begin
                wr_ptr <= (wr_ptr == q_ptr_w'(`CORE_IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (dispatch) begin
                rd_ptr <= (rd_ptr == q_ptr_w'(`CORE_IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                next_id <= next_id + 1'b1;
            end
            q_cnt <= q_cnt + q_cnt_w'(instr_valid) - q_cnt_w'(dispatch);
            // One input credit back per popped entry
            instr_credit <= dispatch;
            id_cnt <= id_cnt + id_cnt_w'(id_credit) - id_cnt_w'(dispatch);
        end
    end

    // Queue storage
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            q_mem[wr_ptr] <= instr;
        end
    end

    ////////////////////////////////////////////////////////////
    // Register busy bits
    // New writer wins over a retirement to the same register
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_busy <= '0;
        end else begin
            for (int r = 1; r < `CORE_NUM_REGS; r++) begin
                if (dispatch && head.r_form.rd == core_pkg::reg_addr_t'(r)) begin
                    reg_busy[r] <= 1'b1;
                end else if (retire.valid && retire.rd == core_pkg::reg_addr_t'(r)
                             && retire.id == last_writer[r]) begin
                    reg_busy[r] <= 1'b0;
                end
            end
        end
    end

    // Youngest writer ID per register
    always_ff @(posedge clk) begin
        if (dispatch) begin
            last_writer[head.r_form.rd] <= next_id;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    // Source must respect its input credits
    a_no_send_when_full: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> (q_cnt < q_cnt_w'(`CORE_IN_DEPTH)))
        else $error("input word sent without a credit");

    // Write-back never returns more credits than issued
    a_id_credit_bound: assert property (@(posedge clk) disable iff (rst)
        id_cnt <= id_cnt_w'(`CORE_NUM_IDS))
        else $error("ID credit count above limit");

endmodule

`default_nettype wire

/* src/alu_unit.sv */
////////////////////////////////////////////////////////////
// ALU unit
// Single-cycle add, sub, xor and addi, registered result
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module alu_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  core_pkg::unit_issue_t issue,
    output core_pkg::unit_wb_t    wb
);

    logic [`CORE_XLEN-1:0] result, result_r;
    core_pkg::instr_id_t id_r;
    logic done_r;

    // Wrapping 32-bit arithmetic, immediate already extended
    always_comb begin
        case (issue.opcode)
            core_pkg::op_add,
            core_pkg::op_addi: result = issue.a + issue.b;
            core_pkg::op_sub:  result = issue.a - issue.b;
            core_pkg::op_xor:  result = issue.a ^ issue.b;
            default:           result = '0;
        endcase
    end

    // Done flag one cycle after dispatch
    always_ff @(posedge clk) begin
        if (rst) begin
            done_r <= 1'b0;
        end else begin
            done_r <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            id_r <= issue.id;
            result_r <= result;
        end
    end

    assign wb = '{done: done_r, id: id_r, result: result_r};

endmodule

`default_nettype wire

/* src/mul_unit.sv */
////////////////////////////////////////////////////////////
// Multiplier unit
// Iterative shift-add, one multiplier bit per cycle,
// stops as soon as the remaining multiplier bits are zero
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module mul_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  core_pkg::unit_issue_t issue,
    output logic                  busy,
    output core_pkg::unit_wb_t    wb
);

    logic busy_r, done_r, step;
    core_pkg::instr_id_t id_r;
    logic [`CORE_XLEN-1:0] acc, mcand, mplier;
    logic [`CORE_XLEN-1:0] src_acc, src_mcand, src_mplier;
    logic [`CORE_XLEN-1:0] acc_next, mcand_next, mplier_next;

    // First step runs on the dispatch edge from the raw operands
    assign step = issue.valid || busy_r;

    always_comb begin
        src_acc = issue.valid ? '0 : acc;
        src_mcand = issue.valid ? issue.a : mcand;
        src_mplier = issue.valid ? issue.b : mplier;
        // Add when the low multiplier bit is set
        acc_next = src_acc + (src_mplier[0] ? src_mcand : '0);
        mcand_next = src_mcand << 1;
        mplier_next = src_mplier >> 1;
    end

    // Busy drops in the cycle done rises
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_r <= 1'b0;
            done_r <= 1'b0;
        end else begin
            done_r <= step && (mplier_next == '0);
            busy_r <= step && (mplier_next != '0);
        end
    end

    // Accumulator holds the low product once done
    always_ff @(posedge clk) begin
        if (step) begin
            acc <= acc_next;
            mcand <= mcand_next;
            mplier <= mplier_next;
        end
        if (issue.valid) begin
            id_r <= issue.id;
        end
    end

    assign busy = busy_r;
    assign wb = '{done: done_r, id: id_r, result: acc};

    // Issue stage must hold multiplies while busy
    a_no_issue_while_busy: assert property (@(posedge clk) disable iff (rst)
        issue.valid |-> !busy_r)
        else $error("multiply issued while busy");

endmodule

`default_nettype wire

/* src/write_back.sv */
////////////////////////////////////////////////////////////
// Write-back stage
// Per-ID commit buffer filled out of order by the units,
// retired in ID order one per cycle, with ID credit return
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module write_back (
    input  logic                 clk,
    input  logic                 rst,
    input  core_pkg::id_alloc_t  id_alloc,
    input  core_pkg::unit_wb_t   alu_wb,
    input  core_pkg::unit_wb_t   mul_wb,
    output core_pkg::retire_t    retire,
    output logic                 id_credit
);

    localparam int num_ids = `CORE_NUM_IDS;

    // Commit buffer and destination metadata
    logic [`CORE_XLEN-1:0] results [num_ids];
    core_pkg::reg_addr_t meta_rd [num_ids];

    logic [num_ids-1:0] writing, pending, pending_r, retiring_oh;
    core_pkg::instr_id_t oldest_id, retire_id;
    logic retire_next, retire_valid;

    ////////////////////////////////////////////////////////////
    // Done decode per ID
    // Both units may finish together with different IDs
    always_comb begin
        writing = '0;
        for (int i = 0; i < num_ids; i++) begin
            writing[i] = (alu_wb.done && alu_wb.id == core_pkg::instr_id_t'(i))
                      || (mul_wb.done && mul_wb.id == core_pkg::instr_id_t'(i));
        end
    end

    // Results land at the edge where done is high
    always_ff @(posedge clk) begin
        if (alu_wb.done) begin
            results[alu_wb.id] <= alu_wb.result;
        end
        if (mul_wb.done) begin
            results[mul_wb.id] <= mul_wb.result;
        end
    end

    // rd recorded at allocation
    always_ff @(posedge clk) begin
        if (id_alloc.valid) begin
            meta_rd[id_alloc.id] <= id_alloc.rd;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pending tracking and in-order retirement
    always_comb begin
        retiring_oh = '0;
        retiring_oh[retire_id] = retire_valid;
    end

    // Set by done, cleared while presented on retire
    assign pending = writing | (pending_r & ~retiring_oh);

    // Oldest ID ready means it retires next cycle
    assign retire_next = pending[oldest_id];

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_r <= '0;
            retire_valid <= 1'b0;
            oldest_id <= '0;
        end else begin
            pending_r <= pending;
            retire_valid <= retire_next;
            if (retire_next) begin
                oldest_id <= oldest_id + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        retire_id <= oldest_id;
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    assign retire = '{valid: retire_valid, id: retire_id,
                      rd: meta_rd[retire_id], data: results[retire_id]};

    // One ID credit per retirement cycle
    assign id_credit = retire_valid;

    // A unit never completes an ID that is still waiting
    a_done_not_pending: assert property (@(posedge clk) disable iff (rst)
        (writing & pending_r) == '0)
        else $error("done reported for a pending ID");

endmodule

`default_nettype wire

/* src/reg_file.sv */
////////////////////////////////////////////////////////////
// Register file
// Two combinational reads, one write from retirement,
// register 0 reads zero
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  core_pkg::reg_addr_t   rs1_addr,
    input  core_pkg::reg_addr_t   rs2_addr,
    output logic [`CORE_XLEN-1:0] rs1_data,
    output logic [`CORE_XLEN-1:0] rs2_data,
    input  core_pkg::retire_t     retire
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NUM_REGS];

    // Written at the edge that ends the retire cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid && retire.rd != '0) begin
            // Writes to register 0 dropped
            regs[retire.rd] <= retire.data;
        end
    end

    // Read ports
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* src/core_top.sv */
////////////////////////////////////////////////////////////
// Core top
// Issue, ALU, multiplier, write-back and register file,
// instruction input in, retire stream out
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  core_pkg::instr_word_u instr,
    output logic                  instr_credit,
    output core_pkg::retire_t     retire
);

    // Register file read path
    core_pkg::reg_addr_t rs1_addr, rs2_addr;
    logic [`CORE_XLEN-1:0] rs1_data, rs2_data;

    // Dispatch and completion
    core_pkg::unit_issue_t alu_issue, mul_issue;
    core_pkg::unit_wb_t alu_wb, mul_wb;
    core_pkg::id_alloc_t id_alloc;
    logic mul_busy, id_credit;

    issue_stage u_issue (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_credit (instr_credit),
        .id_credit    (id_credit),
        .mul_busy     (mul_busy),
        .retire       (retire),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .alu_issue    (alu_issue),
        .mul_issue    (mul_issue),
        .id_alloc     (id_alloc)
    );

    alu_unit u_alu (
        .clk   (clk),
        .rst   (rst),
        .issue (alu_issue),
        .wb    (alu_wb)
    );

    mul_unit u_mul (
        .clk   (clk),
        .rst   (rst),
        .issue (mul_issue),
        .busy  (mul_busy),
        .wb    (mul_wb)
    );

    // In-order commit
    write_back u_wb (
        .clk       (clk),
        .rst       (rst),
        .id_alloc  (id_alloc),
        .alu_wb    (alu_wb),
        .mul_wb    (mul_wb),
        .retire    (retire),
        .id_credit (id_credit)
    );

    reg_file u_rf (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .retire   (retire)
    );

endmodule

`default_nettype wire

/* sim/tb_core.sv */
////////////////////////////////////////////////////////////
// Core testbench
// Trace-driven stimulus with input credits, in-order
// retire checker and a watchdog sized from the trace
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module tb_core;

    localparam int clk_period = 10;
    localparam int reset_cycles = 16;
    localparam int max_tests = 8;
    localparam logic [31:0] seed = 32'ha5a1_5cc6;

    logic clk = 1'b0;
    logic rst;
    logic instr_valid;
    core_pkg::instr_word_u instr;
    logic instr_credit;
    core_pkg::retire_t retire;

    // Trace contents, expected entries in program order
    logic [31:0] instr_words [$];
    int gaps [$];
    int exp_test [$];
    int exp_rd [$];
    logic [31:0] exp_data [$];

    // Per test bookkeeping
    string test_names [max_tests];
    int test_total [max_tests];
    int test_done [max_tests];
    int test_errs [max_tests];
    int num_tests = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int other_errs = 0;

    // Driver and checker state
    int credits = `CORE_IN_DEPTH;
    int neg_cnt = 0;
    int send_idx = 0;
    int idle_cnt = 0;
    int exp_idx = 0;
    logic trace_loaded = 1'b0;

    core_top dut (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_credit (instr_credit),
        .retire       (retire)
    );

    always #(clk_period / 2) clk = ~clk;

    // Index of a test name, added on first use
    function automatic int find_test(string name);
        for (int i = 0; i < num_tests; i++) begin
            if (test_names[i] == name) begin
                return i;
            end
        end
        test_names[num_tests] = name;
        num_tests++;
        return num_tests - 1;
    endfunction

    ////////////////////////////////////////////////////////////
    // Trace reader
    task automatic load_trace();
        int fd;
        int code;
        int t;
        int rd;
        string kind;
        string name;
        string rest;
        logic [31:0] word;
        fd = $fopen("sim/core_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file sim/core_trace.txt");
            other_errs++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                break;
            end
            if (kind == "#") begin
                code = $fgets(rest, fd);
            end else if (kind == "I") begin
                code = $fscanf(fd, "%s %h", name, word);
                instr_words.push_back(word);
            end else if (kind == "E") begin
                code = $fscanf(fd, "%s %d %h", name, rd, word);
                t = find_test(name);
                exp_test.push_back(t);
                exp_rd.push_back(rd);
                exp_data.push_back(word);
                test_total[t]++;
            end else begin
                $display("Trace line of unknown kind %s", kind);
                other_errs++;
            end
        end
        $fclose(fd);
        // Every instruction retires exactly once
        if (exp_rd.size() != instr_words.size()) begin
            $display("Trace holds %0d instructions but %0d expected retirements",
                     instr_words.size(), exp_rd.size());
            other_errs++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Driver, falling edge, sends only while holding a credit
    task automatic drive_inputs();
        int avail;
        neg_cnt++;
        avail = credits + (instr_credit ? 1 : 0);
        assert (avail <= `CORE_IN_DEPTH) else begin
            $display("Input credit returned while the source already held all credits");
            other_errs++;
        end
        rst = (neg_cnt < reset_cycles);
        instr_valid = 1'b0;
        if (neg_cnt > reset_cycles && send_idx < instr_words.size()) begin
            // Random idle gap before each word
            if (idle_cnt < gaps[send_idx]) begin
                idle_cnt++;
            end else if (avail > 0) begin
                instr = instr_words[send_idx];
                instr_valid = 1'b1;
                avail--;
                send_idx++;
                idle_cnt = 0;
            end
        end
        credits = avail;
    endtask

    // Test summary line once its last retirement is seen
    task automatic finish_test(int t);
        if (test_errs[t] == 0) begin
            tests_passed++;
            $display("Test %s passed, %0d retirements", test_names[t], test_done[t]);
        end else begin
            tests_failed++;
            $display("Test %s failed, %0d errors", test_names[t], test_errs[t]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // In-order retire checker
    task automatic check_retire();
        int k;
        int t;
        if (retire.valid) begin
            assert (exp_idx < exp_rd.size()) else begin
                $display("Retirement of ID %0d rd %0d arrived with no expected entry left",
                         retire.id, retire.rd);
                other_errs++;
            end
            if (exp_idx < exp_rd.size()) begin
                k = exp_idx;
                t = exp_test[k];
                // IDs go round-robin in program order
                assert (retire.id == core_pkg::instr_id_t'(k % `CORE_NUM_IDS)) else begin
                    $display("Error: test %s id expected %0d actual %0d",
                             test_names[t], k % `CORE_NUM_IDS, retire.id);
                    test_errs[t]++;
                end
                assert (retire.rd == core_pkg::reg_addr_t'(exp_rd[k])) else begin
                    $display("Error: test %s rd expected %0d actual %0d",
                             test_names[t], exp_rd[k], retire.rd);
                    test_errs[t]++;
                end
                assert (retire.data == exp_data[k]) else begin
                    $display("Error: test %s data expected %h actual %h",
                             test_names[t], exp_data[k], retire.data);
                    test_errs[t]++;
                end
                test_done[t]++;
                exp_idx++;
                if (test_done[t] == test_total[t]) begin
                    finish_test(t);
                end
            end
        end
    endtask

    always @(negedge clk) begin
        check_retire();
        drive_inputs();
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        void'($urandom(seed));
        load_trace();
        foreach (instr_words[i]) begin
            gaps.push_back(int'($urandom % 3));
        end
        trace_loaded = 1'b1;
        wait (exp_idx >= exp_rd.size());
        // A few more cycles to catch stray retirements
        repeat (10) @(posedge clk);
        assert (credits == `CORE_IN_DEPTH) else begin
            $display("Input credits not all returned, %0d held at the end", credits);
            other_errs++;
        end
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && other_errs == 0 && tests_passed > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog, reset plus 40 cycles per instruction plus slack
    initial begin : watchdog
        int limit;
        wait (trace_loaded);
        limit = reset_cycles + 40 * instr_words.size() + 100;
        #(limit * clk_period);
        for (int t = 0; t < num_tests; t++) begin
            if (test_done[t] < test_total[t]) begin
                $display("Test %s never finished, %0d of %0d instructions retired",
                         test_names[t], test_done[t], test_total[t]);
            end
        end
        $display("Timeout after %0d cycles", limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+src
src/core_pkg.sv
src/issue_stage.sv
src/alu_unit.sv
src/mul_unit.sv
src/write_back.sv
src/reg_file.sv
src/core_top.sv
sim/tb_core.sv

/* sim/core_trace.txt */
# I <test> <instruction word, hex>
# E <test> <rd, decimal> <retired data, hex>
# ALU ops with negative immediates and wrap
I alu_ops 31001234
E alu_ops 1 00001234
I alu_ops 3200FFFF
E alu_ops 2 FFFFFFFF
I alu_ops 33008000
E alu_ops 3 FFFF8000
I alu_ops 14130000
E alu_ops 4 00009234
# ALU results finish before the multiply but retire after it
I mul_order 45230000
E mul_order 5 00008000
I mul_order 26120000
E mul_order 6 FFFFEDCB
I mul_order 47100000
E mul_order 7 00000000
I mul_order 38000007
E mul_order 8 00000007
# Each instruction reads the previous result
I dep_chain 09840000
E dep_chain 9 0000923B
I dep_chain 4A980000
E dep_chain 10 0003FF9D
I dep_chain 19A90000
E dep_chain 9 00036D62
# Register 0 write retires, reads stay zero
I reg_zero 30800077
E reg_zero 0 0000007E
I reg_zero 0B080000
E reg_zero 11 00000007
# Back to back multiplies wrapping the IDs
I mul_burst 4C180000
E mul_burst 12 00007F6C
I mul_burst 4D220000
E mul_burst 13 00000001
I mul_burst 4E480000
E mul_burst 14 0003FF6C
I mul_burst 4F680000
E mul_burst 15 FFFF808D
I mul_burst 47300000
E mul_burst 7 00000000
I mul_burst 4C550000
E mul_burst 12 40000000
I mul_burst 4D160000
E mul_burst 13 FEB4933C
I mul_burst 4EB30000
E mul_burst 14 FFFC8000
I mul_burst 4FAB0000
E mul_burst 15 001BFD4B
